//--- src/bpred_consts.svh
// ----------------------------------------
// Sizes for the branch-predicting front end.
// GHR_BITS also sets the pattern table depth.
// ----------------------------------------
`ifndef BPRED_CONSTS_SVH
`define BPRED_CONSTS_SVH

// Reset value of the fetch PC
`define PC_START 32'h0000_0000

// Width of a PC and of an instruction word
`define XLEN 32

// Direct-mapped BTB, power of two
`define BTB_ENTRIES 32

// Global history length
`define GHR_BITS 5

`endif

//--- src/rvIsaPkg.sv
// ----------------------------------------
// RV32I encodings needed by the front end.
// Only conditional branches and jal are named.
// ----------------------------------------
package rvIsaPkg;

    // Major and minor opcode fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // Branch conditions the front end can resolve
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // Field positions inside an instruction word
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;

    // Immediates always take their sign from the top bit
    localparam int SIGN_BIT = 31;

endpackage

//--- src/bpredPkg.sv
// ----------------------------------------
// Predictor state and pipeline payload types.
// A payload with valid low is a bubble.
// ----------------------------------------
`include "bpred_consts.svh"

package bpredPkg;
    import rvIsaPkg::*;

    localparam int BTB_IDX_BITS = $clog2(`BTB_ENTRIES);
    // PC bits above the index and the byte offset
    localparam int BTB_TAG_BITS = `XLEN - BTB_IDX_BITS - 2;
    localparam int PHT_ENTRIES  = 1 << `GHR_BITS;

    // Two-bit saturating counter, upper half predicts taken
    typedef logic [1:0] counter_t;

    localparam counter_t CNT_MIN     = 2'd0;
    localparam counter_t CNT_WEAK_NT = 2'd1;
    localparam counter_t CNT_WEAK_T  = 2'd2;
    localparam counter_t CNT_MAX     = 2'd3;

    typedef logic [`GHR_BITS-1:0]   phtIdx_t;
    typedef logic [BTB_IDX_BITS-1:0] btbIdx_t;
    typedef logic [BTB_TAG_BITS-1:0] btbTag_t;

    // Fetch to decode
    // predTarget rides along so execute can check the BTB target
    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
        logic             predTaken;
        logic [`XLEN-1:0] predTarget;
        phtIdx_t          phtIdx;
        logic             valid;
    } fetchPayload_t;

    // Decode to execute
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        opcode_t          opcode;
        funct3_t          funct3;
        logic [`XLEN-1:0] imm;
        logic             predTaken;
        logic [`XLEN-1:0] predTarget;
        phtIdx_t          phtIdx;
        logic             valid;
    } decodePayload_t;

endpackage

//--- src/stageReg.sv
// ----------------------------------------
// Pipeline register for any packed payload.
// Flush wins over hold; a flushed stage reads all zero.
// ----------------------------------------
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // An all-zero payload carries valid low, so a bubble
    // never updates the predictor or redirects fetch
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- src/immGen.sv
// ----------------------------------------
// Branch and jump target offsets only.
// Other opcodes yield zero.
// ----------------------------------------
`timescale 1ns/1ps
`include "bpred_consts.svh"

module immGen import rvIsaPkg::*; (
    input  logic [`XLEN-1:0] instr_i,
    output logic [`XLEN-1:0] imm_o
);

    opcode_t opcode;
    logic    sign;

    assign opcode = instr_i[OPCODE_MSB:OPCODE_LSB];
    assign sign   = instr_i[SIGN_BIT];

    always_comb begin
        case (opcode)
            // B-type, offset in multiples of two bytes
            OP_BRANCH: begin
                imm_o = {{(`XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            // J-type, 21-bit signed offset
            OP_JAL: begin
                imm_o = {{(`XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- src/branchPredictor.sv
// ----------------------------------------
// Gshare predictor with a direct-mapped tagged BTB.
// Lookup is combinational, updates land on the next edge.
// ----------------------------------------
`timescale 1ns/1ps
`include "bpred_consts.svh"

module branchPredictor import bpredPkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] pc_i,
    input  logic             btbWrite_i,
    input  btbIdx_t          btbIdx_i,
    input  btbTag_t          btbTag_i,
    input  logic [`XLEN-1:0] btbTarget_i,
    input  logic             btbJump_i,
    input  logic             phtWrite_i,
    input  phtIdx_t          phtIdx_i,
    input  logic             taken_i,
    input  logic             historyShift_i,
    output logic             predTaken_o,
    output logic [`XLEN-1:0] predTarget_o,
    output phtIdx_t          phtIdx_o
);

    // BTB storage
    logic [`BTB_ENTRIES-1:0] btbValid;
    logic [`BTB_ENTRIES-1:0] btbJump;
    btbTag_t                 btbTag    [`BTB_ENTRIES];
    logic [`XLEN-1:0]        btbTarget [`BTB_ENTRIES];

    // Pattern history and global history
    counter_t pht [PHT_ENTRIES];
    phtIdx_t  ghr;

    btbIdx_t  lookupIdx;
    btbTag_t  lookupTag;
    logic     btbHit;
    counter_t lookupCnt;

    // Fetch-time lookup
    assign lookupIdx = pc_i[BTB_IDX_BITS+1:2];
    assign lookupTag = pc_i[`XLEN-1:BTB_IDX_BITS+2];
    assign btbHit    = btbValid[lookupIdx] && (btbTag[lookupIdx] == lookupTag);

    // Gshare index from history and low word-address bits
    assign phtIdx_o  = ghr ^ pc_i[`GHR_BITS+1:2];
    assign lookupCnt = pht[phtIdx_o];

    // Jumps in the BTB are always taken
    assign predTaken_o  = btbHit && (btbJump[lookupIdx] || (lookupCnt >= CNT_WEAK_T));
    assign predTarget_o = btbTarget[lookupIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            btbValid <= '0;
        end else if (btbWrite_i) begin
            btbValid[btbIdx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btbWrite_i) begin
            btbTag[btbIdx_i]    <= btbTag_i;
            btbTarget[btbIdx_i] <= btbTarget_i;
            btbJump[btbIdx_i]   <= btbJump_i;
        end
    end

    // Counters start weakly not-taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CNT_WEAK_NT;
            end
        end else if (phtWrite_i) begin
            if (taken_i && (pht[phtIdx_i] != CNT_MAX)) begin
                pht[phtIdx_i] <= pht[phtIdx_i] + 2'd1;
            end else if (!taken_i && (pht[phtIdx_i] != CNT_MIN)) begin
                pht[phtIdx_i] <= pht[phtIdx_i] - 2'd1;
            end
        end
    end

    // History shifts in the resolved outcome, so it is never speculative
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (historyShift_i) begin
            ghr <= {ghr[`GHR_BITS-2:0], taken_i};
        end
    end

    // Targets come from execute; an odd offset there would poison fetch
    btbTargetAligned: assert property (
        @(posedge clk) disable iff (reset)
        btbWrite_i |-> (btbTarget_i[1:0] == 2'b00)
    ) else $error("BTB write with unaligned target %h", btbTarget_i);

endmodule

//--- src/branchResolve.sv
// ----------------------------------------
// Resolves beq, bne and jal in execute.
// Other branch conditions count as not taken.
// ----------------------------------------
`timescale 1ns/1ps
`include "bpred_consts.svh"

module branchResolve import rvIsaPkg::*, bpredPkg::*; (
    input  decodePayload_t   exec_i,
    input  logic             zero_i,
    output logic             mispredict_o,
    output logic [`XLEN-1:0] correctPc_o,
    output logic             btbWrite_o,
    output btbIdx_t          btbIdx_o,
    output btbTag_t          btbTag_o,
    output logic [`XLEN-1:0] btbTarget_o,
    output logic             btbJump_o,
    output logic             phtWrite_o,
    output phtIdx_t          phtIdx_o,
    output logic             taken_o,
    output logic             historyShift_o
);

    logic             isBranch;
    logic             isJal;
    logic             isCtrl;
    logic             condTrue;
    logic             taken;
    logic [`XLEN-1:0] target;
    logic             dirWrong;
    logic             targetWrong;

    assign isBranch = exec_i.valid && (exec_i.opcode == OP_BRANCH);
    assign isJal    = exec_i.valid && (exec_i.opcode == OP_JAL);
    assign isCtrl   = isBranch || isJal;

    assign condTrue = ((exec_i.funct3 == F3_BEQ) && zero_i) ||
                      ((exec_i.funct3 == F3_BNE) && !zero_i);
    assign taken    = isJal || (isBranch && condTrue);
    assign target   = exec_i.pc + exec_i.imm;

    // Wrong direction, or a non-control instruction that aliased a BTB entry
    assign dirWrong    = (isCtrl && (exec_i.predTaken != taken)) ||
                         (exec_i.valid && !isCtrl && exec_i.predTaken);
    // Right direction but a stale BTB target
    assign targetWrong = taken && exec_i.predTaken && (exec_i.predTarget != target);

    assign mispredict_o = dirWrong || targetWrong;
    assign correctPc_o  = taken ? target : exec_i.pc + `XLEN'd4;

    // Only taken control transfers allocate in the BTB
    assign btbWrite_o  = taken;
    assign btbIdx_o    = exec_i.pc[BTB_IDX_BITS+1:2];
    assign btbTag_o    = exec_i.pc[`XLEN-1:BTB_IDX_BITS+2];
    assign btbTarget_o = target;
    assign btbJump_o   = isJal;

    assign phtWrite_o     = isBranch;
    assign phtIdx_o       = exec_i.phtIdx;
    assign taken_o        = taken;
    assign historyShift_o = isBranch;

endmodule

//--- src/fetchFrontEnd.sv
// ----------------------------------------
// Fetch, decode and execute of one issue slot.
// A misprediction overrides stall; targets must be word aligned.
// ----------------------------------------
`timescale 1ns/1ps
`include "bpred_consts.svh"

module fetchFrontEnd import rvIsaPkg::*, bpredPkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] instrF_i,
    input  logic             zeroE_i,
    input  logic             stall_i,
    output logic [`XLEN-1:0] pcF_o,
    output logic             mispredictE_o
);

    // Fetch stage
    logic             predTakenF;
    logic [`XLEN-1:0] predTargetF;
    phtIdx_t          phtIdxF;
    logic [`XLEN-1:0] pcPlus4F;
    logic [`XLEN-1:0] nextPcF;
    fetchPayload_t    fetchD;

    // Decode stage
    fetchPayload_t    fetchQ;
    logic [`XLEN-1:0] immD;
    decodePayload_t   decodeD;

    // Execute stage
    decodePayload_t   execQ;
    logic [`XLEN-1:0] correctPcE;
    logic             btbWriteE;
    btbIdx_t          btbIdxE;
    btbTag_t          btbTagE;
    logic [`XLEN-1:0] btbTargetE;
    logic             btbJumpE;
    logic             phtWriteE;
    phtIdx_t          phtIdxE;
    logic             takenE;
    logic             historyShiftE;

    branchPredictor predictor (
        .clk            (clk),
        .reset          (reset),
        .pc_i           (pcF_o),
        .btbWrite_i     (btbWriteE),
        .btbIdx_i       (btbIdxE),
        .btbTag_i       (btbTagE),
        .btbTarget_i    (btbTargetE),
        .btbJump_i      (btbJumpE),
        .phtWrite_i     (phtWriteE),
        .phtIdx_i       (phtIdxE),
        .taken_i        (takenE),
        .historyShift_i (historyShiftE),
        .predTaken_o    (predTakenF),
        .predTarget_o   (predTargetF),
        .phtIdx_o       (phtIdxF)
    );

    // Next PC, redirect from execute first
    assign pcPlus4F = pcF_o + `XLEN'd4;
    assign nextPcF  = mispredictE_o ? correctPcE :
                      predTakenF    ? predTargetF : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `PC_START;
        end else if (mispredictE_o || !stall_i) begin
            pcF_o <= nextPcF;
        end
    end

    always_comb begin
        fetchD.instr      = instrF_i;
        fetchD.pc         = pcF_o;
        fetchD.predTaken  = predTakenF;
        fetchD.predTarget = predTargetF;
        fetchD.phtIdx     = phtIdxF;
        fetchD.valid      = 1'b1;
    end

    // Decode holds on a stall so the fetched word is not lost
    stageReg #(.payload_t(fetchPayload_t)) fetchReg (
        .clk     (clk),
        .reset   (reset),
        .hold_i  (stall_i),
        .flush_i (mispredictE_o),
        .d_i     (fetchD),
        .q_o     (fetchQ)
    );

    immGen immGenD (
        .instr_i (fetchQ.instr),
        .imm_o   (immD)
    );

    always_comb begin
        decodeD.pc         = fetchQ.pc;
        decodeD.opcode     = fetchQ.instr[OPCODE_MSB:OPCODE_LSB];
        decodeD.funct3     = fetchQ.instr[FUNCT3_MSB:FUNCT3_LSB];
        decodeD.imm        = immD;
        decodeD.predTaken  = fetchQ.predTaken;
        decodeD.predTarget = fetchQ.predTarget;
        decodeD.phtIdx     = fetchQ.phtIdx;
        decodeD.valid      = fetchQ.valid;
    end

    // Execute takes a bubble while decode is stalled
    stageReg #(.payload_t(decodePayload_t)) decodeReg (
        .clk     (clk),
        .reset   (reset),
        .hold_i  (1'b0),
        .flush_i (mispredictE_o || stall_i),
        .d_i     (decodeD),
        .q_o     (execQ)
    );

    branchResolve resolve (
        .exec_i         (execQ),
        .zero_i         (zeroE_i),
        .mispredict_o   (mispredictE_o),
        .correctPc_o    (correctPcE),
        .btbWrite_o     (btbWriteE),
        .btbIdx_o       (btbIdxE),
        .btbTag_o       (btbTagE),
        .btbTarget_o    (btbTargetE),
        .btbJump_o      (btbJumpE),
        .phtWrite_o     (phtWriteE),
        .phtIdx_o       (phtIdxE),
        .taken_o        (takenE),
        .historyShift_o (historyShiftE)
    );

    // Holds across reset value, BTB targets and execute redirects alike
    pcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pcF_o[1:0] == 2'b00
    ) else $error("fetch PC %h is not word aligned", pcF_o);

endmodule

//--- dv/frontEndModel.svh
// ----------------------------------------
// Cycle model of fetch, decode, execute and the predictor.
// The program comes from memKind and memImm, indexed by PC word mod 64.
// ----------------------------------------
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

localparam int KIND_BEQ  = 0;
localparam int KIND_BNE  = 1;
localparam int KIND_JAL  = 2;
localparam int KIND_ADDI = 3;
localparam int PHT_SIZE  = 1 << `GHR_BITS;

// One pipeline stage as the model sees it
typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    int          kind;
    logic [31:0] imm;
    logic        predTaken;
    logic [31:0] predTarget;
    int          phtIdx;
} modelStage_t;

logic [31:0] memWord [64];
int          memKind [64];
logic [31:0] memImm  [64];

logic [31:0] mPc;
modelStage_t mDec;
modelStage_t mExe;
logic        mBtbValid  [`BTB_ENTRIES];
logic        mBtbJump   [`BTB_ENTRIES];
int          mBtbTag    [`BTB_ENTRIES];
logic [31:0] mBtbTarget [`BTB_ENTRIES];
int          mPht       [PHT_SIZE];
int          mGhr;

// Outcome of the instruction now in execute
logic        mTaken;
logic        mMis;
logic [31:0] mTarget;
logic [31:0] mCorrect;

function automatic void modelReset();
    mPc  = `PC_START;
    mDec = '0;
    mExe = '0;
    mGhr = 0;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
        mBtbValid[i] = 1'b0;
    end
    // Weakly not-taken
    for (int i = 0; i < PHT_SIZE; i++) begin
        mPht[i] = 1;
    end
endfunction

function automatic void modelResolve(input logic zero);
    logic isBranch;
    logic isJal;
    isBranch = mExe.valid && (mExe.kind == KIND_BEQ || mExe.kind == KIND_BNE);
    isJal    = mExe.valid && (mExe.kind == KIND_JAL);
    mTaken   = isJal || (isBranch && ((mExe.kind == KIND_BEQ) ? zero : !zero));
    mTarget  = mExe.pc + mExe.imm;
    mCorrect = mTaken ? mTarget : mExe.pc + 4;
    if (isBranch || isJal) begin
        mMis = (mExe.predTaken != mTaken) || (mTaken && (mExe.predTarget != mTarget));
    end else begin
        mMis = mExe.valid && mExe.predTaken;
    end
endfunction

// Advances the model by one rising edge
function automatic void modelStep(input logic stall);
    int          word;
    int          btbIdx;
    int          exeIdx;
    logic        hit;
    modelStage_t fetched;
    word   = mPc / 4;
    btbIdx = word % `BTB_ENTRIES;
    hit    = mBtbValid[btbIdx] && (mBtbTag[btbIdx] == word / `BTB_ENTRIES);
    fetched.valid      = 1'b1;
    fetched.pc         = mPc;
    fetched.kind       = memKind[word % 64];
    fetched.imm        = memImm[word % 64];
    fetched.phtIdx     = (mGhr ^ word) % PHT_SIZE;
    fetched.predTaken  = hit && (mBtbJump[btbIdx] || (mPht[fetched.phtIdx] >= 2));
    fetched.predTarget = mBtbTarget[btbIdx];
    // Training from execute, seen by fetch only after this edge
    if (mExe.valid && mTaken) begin
        exeIdx = (mExe.pc / 4) % `BTB_ENTRIES;
        mBtbValid[exeIdx]  = 1'b1;
        mBtbTag[exeIdx]    = (mExe.pc / 4) / `BTB_ENTRIES;
        mBtbTarget[exeIdx] = mTarget;
        mBtbJump[exeIdx]   = (mExe.kind == KIND_JAL);
    end
    if (mExe.valid && (mExe.kind == KIND_BEQ || mExe.kind == KIND_BNE)) begin
        if (mTaken && mPht[mExe.phtIdx] < 3) begin
            mPht[mExe.phtIdx]++;
        end else if (!mTaken && mPht[mExe.phtIdx] > 0) begin
            mPht[mExe.phtIdx]--;
        end
        mGhr = (mGhr * 2 + (mTaken ? 1 : 0)) % PHT_SIZE;
    end
    if (mMis) begin
        mPc = mCorrect;
    end else if (!stall) begin
        mPc = fetched.predTaken ? fetched.predTarget : mPc + 4;
    end
    if (mMis || stall) begin
        mExe.valid = 1'b0;
    end else begin
        mExe = mDec;
    end
    if (mMis) begin
        mDec.valid = 1'b0;
    end else if (!stall) begin
        mDec = fetched;
    end
endfunction

`endif

//--- dv/frontEndTb.sv
// ----------------------------------------
// Runs fetchFrontEnd against a cycle model and stops at the first error.
// Inputs change on the falling edge; the program repeats every 64 words.
// ----------------------------------------
`timescale 1ns/1ps
`include "bpred_consts.svh"

module frontEndTb;

    localparam int RESET_CYCLES    = 8;
    localparam int STRAIGHT_CYCLES = 16;
    localparam int LOOP_CYCLES     = 80;
    localparam int EXIT_CYCLES     = 12;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TEST_CYCLES     = STRAIGHT_CYCLES + LOOP_CYCLES + EXIT_CYCLES
                                     + RANDOM_CYCLES;
    // Three resets, one before each program
    localparam int WATCHDOG_NS     = (3 * RESET_CYCLES + TEST_CYCLES + 100) * 10;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] instrF_i;
    logic             zeroE_i;
    logic             stall_i;
    logic [`XLEN-1:0] pcF_o;
    logic             mispredictE_o;
    logic [15:0]      lfsr;
    int               missCount;

    `include "frontEndModel.svh"

    fetchFrontEnd UUT (
        .clk           (clk),
        .reset         (reset),
        .instrF_i      (instrF_i),
        .zeroE_i       (zeroE_i),
        .stall_i       (stall_i),
        .pcF_o         (pcF_o),
        .mispredictE_o (mispredictE_o)
    );

    always #5 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // RV32I B, J and I formats with fixed registers
    function automatic logic [31:0] encode(input int kind, input logic [31:0] off);
        case (kind)
            KIND_BEQ, KIND_BNE: return {off[12], off[10:5], 5'd2, 5'd1,
                                        (kind == KIND_BNE) ? 3'b001 : 3'b000,
                                        off[4:1], off[11], 7'b1100011};
            KIND_JAL: return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
            default:  return {12'h001, 5'd1, 3'b000, 5'd1, 7'b0010011};
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // All addi, optionally with a bne at word 4 back to word 0
    task automatic fillProgram(input logic withLoop);
        for (int k = 0; k < 64; k++) begin
            memKind[k] = KIND_ADDI;
            memImm[k]  = '0;
        end
        if (withLoop) begin
            memKind[4] = KIND_BNE;
            memImm[4]  = -16;
        end
        for (int k = 0; k < 64; k++) begin
            memWord[k] = encode(memKind[k], memImm[k]);
        end
    endtask

    // Branches stay in the window, jal only goes forward so no loop is endless
    task automatic fillRandom();
        int off;
        for (int k = 0; k < 64; k++) begin
            memKind[k] = int'(randBits(2));
            off = int'(randBits(4)) - 8;
            if (k + off < 0 || k + off > 63) begin
                off = -off;
            end
            if (memKind[k] == KIND_JAL) begin
                off = int'(randBits(3)) + 1;
            end
            memImm[k]  = off * 4;
            memWord[k] = encode(memKind[k], memImm[k]);
        end
    endtask

    task automatic applyReset();
        reset   = 1'b1;
        zeroE_i = 1'b0;
        stall_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        modelReset();
    endtask

    // Starts and ends on a falling edge
    task automatic runCycle(input logic zero, input logic stall);
        checkValue("pcF_o", mPc, pcF_o);
        instrF_i = memWord[pcF_o[7:2]];
        zeroE_i  = zero;
        stall_i  = stall;
        #1;
        modelResolve(zero);
        checkValue("mispredictE_o", 32'(mMis), 32'(mispredictE_o));
        if (mispredictE_o) begin
            missCount++;
        end
        modelStep(stall);
        @(negedge clk);
    endtask

    initial begin
        logic zeroBit;
        logic stallBit;
        clk       = 1'b0;
        reset     = 1'b1;
        instrF_i  = '0;
        zeroE_i   = 1'b0;
        stall_i   = 1'b0;
        lfsr      = 16'd7;
        missCount = 0;

        // Straight-line code with a three-cycle stall
        fillProgram(1'b0);
        applyReset();
        for (int c = 0; c < STRAIGHT_CYCLES; c++) begin
            runCycle(1'b0, (c >= 6) && (c < 9));
        end

        // bne stays taken while zero is low, then trains after six passes
        fillProgram(1'b1);
        applyReset();
        missCount = 0;
        repeat (10) runCycle(1'b0, 1'b0);
        checkValue("mispredicts in first loop pass", 1, missCount);
        repeat (LOOP_CYCLES - 40) runCycle(1'b0, 1'b0);
        missCount = 0;
        repeat (30) runCycle(1'b0, 1'b0);
        checkValue("mispredicts in trained loop", 0, missCount);
        // Zero high makes the bne fall through once
        missCount = 0;
        repeat (EXIT_CYCLES) runCycle(1'b1, 1'b0);
        checkValue("mispredicts at loop exit", 1, missCount);

        fillRandom();
        applyReset();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            zeroBit  = (randBits(1) != 0);
            stallBit = (randBits(3) == 0);
            runCycle(zeroBit, stallBit);
        end

        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Testbench failed");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

endmodule

//--- tb.f
+incdir+src
+incdir+dv
src/rvIsaPkg.sv
src/bpredPkg.sv
src/stageReg.sv
src/immGen.sv
src/branchPredictor.sv
src/branchResolve.sv
src/fetchFrontEnd.sv
dv/frontEndTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the front-end testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module frontEndTb \
    --Mdir obj_dir -o frontEndSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/frontEndSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0
